// File: all.f
logic/mem_pkg.sv
logic/rep_addr_gen.sv
logic/dtlb_port.sv
logic/operand_swap.sv
logic/mem_stage.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_mem_stage.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, exit status follows the result
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_mem_stage -f all.f -o sim_mem_stage &&
./obj_dir/sim_mem_stage | tee /dev/stderr | grep -qx '>>> PASS' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tests/tb_mem_stage.sv
`timescale 1ns/100ps

module tb_mem_stage;

    logic                clk;
    logic                arst_n;
    logic                freeze;
    logic                stall;
    mem_pkg::uop_t       uop;
    mem_pkg::tlb_table_t tlb;
    mem_pkg::result_t    result;
    int                  error_count;
    logic [31:0]         rng_state = 32'd65;
    int                  tests_passed = 0;
    int                  tests_failed = 0;

    tb_clock i_tb_clock (.clk_o(clk), .arst_n_o(arst_n));

    mem_stage i_mem_stage (
        .clk      (clk),
        .arst_n_i (arst_n),
        .freeze_i (freeze),
        .uop_i    (uop),
        .tlb_i    (tlb),
        .result_o (result),
        .stall_o  (stall)
    );

    tb_checker i_tb_checker (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .freeze_i      (freeze),
        .result_i      (result),
        .stall_i       (stall),
        .error_count_o (error_count)
    );

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic int below(input int n);
        return int'(xorshift32() % 32'(n));
    endfunction

    // lowest matching entry wins, a miss yields paddr zero
    function automatic mem_pkg::xlat_t translate(input mem_pkg::tlb_table_t t,
                                                 input mem_pkg::addr_t a,
                                                 input mem_pkg::mem_rw_e rw);
        mem_pkg::xlat_t x;
        bit             hit;
        x   = '0;
        hit = 1'b0;
        for (int i = 0; i < mem_pkg::TLB_ENTRIES; i++) begin
            if (!hit && t[i].valid && t[i].present && t[i].vpn == a[31:12]) begin
                hit     = 1'b1;
                x.paddr = {t[i].pfn, a[11:0]};
                x.prot  = (rw == mem_pkg::MEM_WRITE) && !t[i].writable;
            end
        end
        x.miss = (rw != mem_pkg::MEM_NONE) && !hit;
        return x;
    endfunction

    function automatic mem_pkg::result_t expected_beat(input mem_pkg::uop_t u,
                                                       input mem_pkg::tlb_table_t t,
                                                       input int k);
        mem_pkg::result_t r;
        mem_pkg::xlat_t   x1;
        mem_pkg::xlat_t   x2;
        mem_pkg::xlat_t   xd;
        mem_pkg::addr_t   a1;
        mem_pkg::addr_t   a2;
        a1 = u.dir_down ? u.mem_addr1 - mem_pkg::addr_t'(k) : u.mem_addr1 + mem_pkg::addr_t'(k);
        a2 = u.dir_down ? u.mem_addr2 - mem_pkg::addr_t'(k) : u.mem_addr2 + mem_pkg::addr_t'(k);
        x1 = translate(t, a1, u.mem1_rw);
        x2 = translate(t, a2, u.mem2_rw);
        r       = '0;
        r.valid = 1'b1;
        r.eip   = u.eip;
        for (int i = 0; i < mem_pkg::NUM_OPS; i++) begin
            case (u.op_sel[i])
                mem_pkg::SRC_MEM1: r.ops[i] = x1.paddr;
                mem_pkg::SRC_MEM2: r.ops[i] = x2.paddr;
                mem_pkg::SRC_IMM:  r.ops[i] = u.imm;
                mem_pkg::SRC_EIP:  r.ops[i] = u.eip;
                default:           r.ops[i] = u.regs[u.op_sel[i][1:0]];
            endcase
        end
        for (int d = 0; d < mem_pkg::NUM_DESTS; d++) begin
            xd = (d == 0) ? x1 : x2;
            if (u.dest_kind[d] == mem_pkg::DEST_MEM) begin
                r.dest_addr[d]   = xd.paddr;
                r.dest_is_mem[d] = 1'b1;
            end else if (u.dest_kind[d] == mem_pkg::DEST_REG) begin
                r.dest_addr[d] = {30'd0, u.dest_reg[d]};
            end
        end
        r.ie         = u.ie | x1.miss | x2.miss | x1.prot | x2.prot;
        r.ie_type    = u.ie_type;
        r.ie_type[0] = u.ie_type[0] | x1.prot | x2.prot;
        r.ie_type[1] = u.ie_type[1] | x1.miss | x2.miss;
        return r;
    endfunction

    // few distinct pages so duplicates, misses and page crossings all show up
    function automatic mem_pkg::tlb_table_t random_tlb();
        mem_pkg::tlb_table_t t;
        for (int i = 0; i < mem_pkg::TLB_ENTRIES; i++) begin
            t[i].vpn      = 20'h00100 + 20'(below(6));
            t[i].pfn      = 20'(xorshift32());
            t[i].valid    = below(8) != 0;
            t[i].present  = below(6) != 0;
            t[i].writable = below(2) != 0;
        end
        return t;
    endfunction

    function automatic mem_pkg::uop_t random_uop(input bit rep);
        mem_pkg::uop_t u;
        u           = '0;
        u.valid     = 1'b1;
        u.eip       = xorshift32();
        u.mem_addr1 = {20'h00100 + 20'(below(10)), 12'(xorshift32())};
        u.mem_addr2 = {20'h00100 + 20'(below(10)), 12'(xorshift32())};
        u.mem1_rw   = mem_pkg::mem_rw_e'(2'(below(3)));
        u.mem2_rw   = mem_pkg::mem_rw_e'(2'(below(3)));
        for (int i = 0; i < mem_pkg::NUM_OPS; i++) begin
            u.regs[i]   = xorshift32();
            u.op_sel[i] = mem_pkg::op_src_e'(3'(below(8)));
        end
        for (int d = 0; d < mem_pkg::NUM_DESTS; d++) begin
            u.dest_kind[d] = mem_pkg::dest_kind_e'(2'(below(3)));
            u.dest_reg[d]  = 2'(below(4));
        end
        u.imm       = xorshift32();
        u.is_rep    = rep;
        u.rep_count = 16'(below(7));   // ignored unless is_rep is set
        u.dir_down  = below(2) != 0;
        u.ie        = below(8) == 0;
        u.ie_type   = 4'(xorshift32());
        return u;
    endfunction

    // entered on a rising edge, leaves on the edge that takes the last beat
    task automatic play_uop(input mem_pkg::uop_t u, input int frz_pct, output bit timed_out);
        int  k;
        int  guard;
        bit  done;
        bit  has_beat;
        bit  exp_stall;
        bit  taken;
        k     = 0;
        guard = 0;
        done  = 1'b0;
        uop <= u;
        while (!done && guard < 200) begin
            @(negedge clk);
            has_beat  = !u.is_rep || (u.rep_count != 16'd0);
            exp_stall = u.is_rep && (k < int'(u.rep_count) - 1);
            taken     = !freeze;
            i_tb_checker.check_stall(exp_stall);
            @(posedge clk);
            // the output register took this beat on the edge just passed
            if (taken) begin
                if (has_beat) i_tb_checker.expect_result(expected_beat(u, tlb, k));
                if (exp_stall) k++;
                else done = 1'b1;
            end
            freeze <= below(100) < frz_pct;
            guard++;
        end
        timed_out = !done;
    endtask

    task automatic run_test(input string name, input int n, input bit rep, input int frz_pct);
        int err0;
        int guard;
        bit stuck;
        bit lost;
        err0  = error_count;
        stuck = 1'b0;
        @(posedge clk);
        tlb <= random_tlb();
        for (int i = 0; i < n; i++) begin
            bit t1;
            play_uop(random_uop(rep), frz_pct, t1);
            stuck |= t1;
        end
        uop    <= '0;
        freeze <= 1'b0;
        guard = 0;
        while (i_tb_checker.pending() > 0 && guard < 20) begin
            @(posedge clk);
            guard++;
        end
        @(negedge clk);
        @(posedge clk);   // the checker has looked at the last result by now
        lost = i_tb_checker.pending() > 0;
        if (stuck) $display("%s: a micro-op never finished its beats", name);
        if (lost) $display("%s: timeout, expected beats never arrived", name);
        i_tb_checker.drop_pending();
        if (stuck || lost || error_count != err0) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            tests_passed++;
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        int guard;
        int err0;
        freeze <= 1'b0;
        uop    <= '0;
        tlb    <= '0;
        guard = 0;
        while (!arst_n && guard < 20) begin
            @(posedge clk);
            guard++;
        end
        err0 = error_count;
        // nothing may come out while no micro-op is offered
        repeat (4) begin
            @(negedge clk);
            i_tb_checker.check_stall(1'b0);
            if (result.valid !== 1'b0) begin
                i_tb_checker.report("result_o.valid high after reset");
            end
        end
        @(posedge clk);
        if (!arst_n || error_count != err0) begin
            tests_failed++;
            $display("test reset: failed");
        end else begin
            tests_passed++;
            $display("test reset: ok");
        end
        run_test("translate", 60, 1'b0, 0);
        run_test("operands", 60, 1'b0, 0);
        run_test("repeat", 40, 1'b1, 0);
        run_test("freeze", 60, 1'b1, 30);
        run_test("freeze_plain", 40, 1'b0, 30);
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: tests/tb_checker.sv
`timescale 1ns/100ps

module tb_checker (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             freeze_i,
    input  mem_pkg::result_t result_i,
    input  logic             stall_i,
    output int               error_count_o
);

    mem_pkg::result_t exp_q[$];
    mem_pkg::result_t held;
    logic             frz_prev = 1'b0;
    int               errors = 0;

    assign error_count_o = errors;

    task automatic report(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic string first_diff(input mem_pkg::result_t got, input mem_pkg::result_t exp);
        if (got.valid !== exp.valid) return "valid";
        if (got.eip !== exp.eip) return "eip";
        for (int i = 0; i < mem_pkg::NUM_OPS; i++) begin
            if (got.ops[i] !== exp.ops[i]) return $sformatf("ops[%0d]", i);
        end
        for (int d = 0; d < mem_pkg::NUM_DESTS; d++) begin
            if (got.dest_addr[d] !== exp.dest_addr[d]) return $sformatf("dest_addr[%0d]", d);
        end
        if (got.dest_is_mem !== exp.dest_is_mem) return "dest_is_mem";
        if (got.ie !== exp.ie) return "ie";
        if (got.ie_type !== exp.ie_type) return "ie_type";
        return "";
    endfunction

    task automatic expect_result(input mem_pkg::result_t r);
        exp_q.push_back(r);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic drop_pending();
        exp_q.delete();
    endtask

    task automatic check_stall(input logic exp);
        if (stall_i !== exp) report($sformatf("stall_o is %b, expected %b", stall_i, exp));
    endtask

    // the edge just passed registers a new result only if freeze was low before it
    always @(negedge clk_i) begin
        mem_pkg::result_t exp;
        string            field;
        if (arst_n_i) begin
            if (frz_prev) begin
                if (result_i !== held) report("result_o changed while frozen");
            end else if (result_i.valid) begin
                if (exp_q.size() == 0) begin
                    report("a beat came out with none expected");
                end else begin
                    exp = exp_q.pop_front();
                    field = first_diff(result_i, exp);
                    if (field != "") report($sformatf("result_o.%s differs", field));
                end
            end
        end
        held     = result_i;
        frz_prev = freeze_i;
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;   // 10 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/100ps

module mem_stage (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                freeze_i,
    input  mem_pkg::uop_t       uop_i,
    input  mem_pkg::tlb_table_t tlb_i,
    output mem_pkg::result_t    result_o,
    output logic                stall_o
);

    mem_pkg::addr_t beat_addr1;
    mem_pkg::addr_t beat_addr2;
    logic           beat_valid;
    mem_pkg::xlat_t xlat1;
    mem_pkg::xlat_t xlat2;

    // repeat walker sits in front of both translation ports
    rep_addr_gen i_rep_addr_gen (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .freeze_i     (freeze_i),
        .uop_i        (uop_i),
        .beat_addr1_o (beat_addr1),
        .beat_addr2_o (beat_addr2),
        .beat_valid_o (beat_valid),
        .stall_o      (stall_o)
    );

    dtlb_port i_port1 (
        .tlb_i  (tlb_i),
        .addr_i (beat_addr1),
        .rw_i   (uop_i.mem1_rw),
        .xlat_o (xlat1)
    );

    dtlb_port i_port2 (
        .tlb_i  (tlb_i),
        .addr_i (beat_addr2),
        .rw_i   (uop_i.mem2_rw),
        .xlat_o (xlat2)
    );

    operand_swap i_operand_swap (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .freeze_i     (freeze_i),
        .uop_i        (uop_i),
        .beat_valid_i (beat_valid),
        .xlat1_i      (xlat1),
        .xlat2_i      (xlat2),
        .result_o     (result_o)
    );

endmodule

// File: logic/operand_swap.sv
`timescale 1ns/100ps

module operand_swap (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             freeze_i,
    input  mem_pkg::uop_t    uop_i,
    input  logic             beat_valid_i,
    input  mem_pkg::xlat_t   xlat1_i,
    input  mem_pkg::xlat_t   xlat2_i,
    output mem_pkg::result_t result_o
);

    mem_pkg::xlat_t [mem_pkg::NUM_DESTS-1:0] port_xlat;
    mem_pkg::result_t                        next_res;
    mem_pkg::result_t                        res_q;
    logic                                    valid_q;
    logic                                    any_miss;
    logic                                    any_prot;

    function automatic mem_pkg::word_t pick_src(
        input mem_pkg::op_src_e sel,
        input mem_pkg::uop_t    uop,
        input mem_pkg::addr_t   paddr1,
        input mem_pkg::addr_t   paddr2
    );
        mem_pkg::word_t val;
        case (sel)
            mem_pkg::SRC_REG0: val = uop.regs[0];
            mem_pkg::SRC_REG1: val = uop.regs[1];
            mem_pkg::SRC_REG2: val = uop.regs[2];
            mem_pkg::SRC_REG3: val = uop.regs[3];
            mem_pkg::SRC_MEM1: val = paddr1;   // no data read here, the operand is its address
            mem_pkg::SRC_MEM2: val = paddr2;
            mem_pkg::SRC_IMM:  val = uop.imm;
            default:           val = uop.eip;
        endcase
        return val;
    endfunction

    // dest 0 pairs with port 1 and dest 1 with port 2
    assign port_xlat = {xlat2_i, xlat1_i};

    assign any_miss = xlat1_i.miss | xlat2_i.miss;
    assign any_prot = xlat1_i.prot | xlat2_i.prot;

    always_comb begin
        next_res       = '0;
        next_res.valid = beat_valid_i;
        next_res.eip   = uop_i.eip;

        for (int i = 0; i < mem_pkg::NUM_OPS; i++) begin
            next_res.ops[i] = pick_src(uop_i.op_sel[i], uop_i, xlat1_i.paddr, xlat2_i.paddr);
        end

        for (int d = 0; d < mem_pkg::NUM_DESTS; d++) begin
            case (uop_i.dest_kind[d])
                mem_pkg::DEST_MEM: begin
                    next_res.dest_addr[d]   = port_xlat[d].paddr;
                    next_res.dest_is_mem[d] = 1'b1;
                end
                mem_pkg::DEST_REG: begin
                    next_res.dest_addr[d] = mem_pkg::addr_t'(uop_i.dest_reg[d]);
                end
                default: begin
                    next_res.dest_addr[d] = '0;
                end
            endcase
        end

        // bit 0 flags protection, bit 1 a page fault, the upper two come from decode
        next_res.ie      = uop_i.ie | any_miss | any_prot;
        next_res.ie_type = {uop_i.ie_type[3:2],
                            uop_i.ie_type[1] | any_miss,
                            uop_i.ie_type[0] | any_prot};
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (!freeze_i) begin
            valid_q <= next_res.valid;   // a cycle without a beat loads zero
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze_i) begin
            res_q <= next_res;
        end
    end

    always_comb begin
        result_o       = res_q;
        result_o.valid = valid_q;
    end

endmodule

// File: logic/dtlb_port.sv
`timescale 1ns/100ps

module dtlb_port (
    input  mem_pkg::tlb_table_t tlb_i,
    input  mem_pkg::addr_t      addr_i,
    input  mem_pkg::mem_rw_e    rw_i,
    output mem_pkg::xlat_t      xlat_o
);

    logic [mem_pkg::TLB_ENTRIES-1:0] match;
    mem_pkg::vpn_t                   vpn;
    mem_pkg::tlb_entry_t             hit_entry;
    logic                            hit;

    assign vpn = addr_i[31:mem_pkg::OFFSET_W];

    // every entry is compared at once
    always_comb begin
        for (int i = 0; i < mem_pkg::TLB_ENTRIES; i++) begin
            match[i] = tlb_i[i].valid && tlb_i[i].present && (tlb_i[i].vpn == vpn);
        end
    end

    // the lowest matching index wins when the table holds duplicates
    always_comb begin
        hit       = 1'b0;
        hit_entry = '0;
        for (int i = 0; i < mem_pkg::TLB_ENTRIES; i++) begin
            if (match[i] && !hit) begin
                hit       = 1'b1;
                hit_entry = tlb_i[i];
            end
        end
    end

    always_comb begin
        if (hit) begin
            xlat_o.paddr = {hit_entry.pfn, addr_i[mem_pkg::OFFSET_W-1:0]};
        end else begin
            xlat_o.paddr = '0;
        end
        xlat_o.miss = (rw_i != mem_pkg::MEM_NONE) && !hit;   // no access, no page fault
        xlat_o.prot = hit && (rw_i == mem_pkg::MEM_WRITE) && !hit_entry.writable;
    end

endmodule

// File: logic/rep_addr_gen.sv
`timescale 1ns/100ps

module rep_addr_gen (
    input  logic           clk,
    input  logic           arst_n_i,
    input  logic           freeze_i,
    input  mem_pkg::uop_t  uop_i,
    output mem_pkg::addr_t beat_addr1_o,
    output mem_pkg::addr_t beat_addr2_o,
    output logic           beat_valid_o,
    output logic           stall_o
);

    mem_pkg::rep_state_e state_q;
    mem_pkg::count_t     remain_q;   // beats still to go, the current one included
    mem_pkg::addr_t      addr1_q;
    mem_pkg::addr_t      addr2_q;
    mem_pkg::addr_t      step;
    logic                running;
    logic                start_rep;
    logic                last_beat;

    assign running = (state_q == mem_pkg::REP_RUN);

    // minus one is all ones, the add wraps mod 2^32
    assign step = uop_i.dir_down ? '1 : mem_pkg::addr_t'(1);

    // beat zero of any micro-op uses its own addresses straight from upstream
    assign beat_addr1_o = running ? addr1_q : uop_i.mem_addr1;
    assign beat_addr2_o = running ? addr2_q : uop_i.mem_addr2;

    // only a repeat of two or more beats needs the registered walk
    assign start_rep = !running && uop_i.valid && uop_i.is_rep &&
                       (uop_i.rep_count > mem_pkg::count_t'(1));

    assign last_beat = running && (remain_q == mem_pkg::count_t'(1));

    assign beat_valid_o = running ||
                          (uop_i.valid && (!uop_i.is_rep || (uop_i.rep_count != '0)));

    // upstream holds the micro-op until the last beat is current
    assign stall_o = start_rep || (running && !last_beat);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= mem_pkg::REP_IDLE;
            remain_q <= '0;
        end else if (!freeze_i) begin
            if (start_rep) begin
                state_q  <= mem_pkg::REP_RUN;
                remain_q <= uop_i.rep_count - mem_pkg::count_t'(1);
            end else if (last_beat) begin
                state_q <= mem_pkg::REP_IDLE;
            end else if (running) begin
                remain_q <= remain_q - mem_pkg::count_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze_i && (start_rep || running)) begin
            addr1_q <= beat_addr1_o + step;   // both pointers move together
            addr2_q <= beat_addr2_o + step;
        end
    end

endmodule

// File: logic/mem_pkg.sv
package mem_pkg;

    localparam int TLB_ENTRIES = 8;
    localparam int NUM_OPS     = 4;    // operand slots, also the number of source registers
    localparam int NUM_DESTS   = 2;
    localparam int OFFSET_W    = 12;   // 4k pages

    typedef logic [31:0]          word_t;
    typedef logic [31:0]          addr_t;
    typedef logic [31-OFFSET_W:0] vpn_t;
    typedef logic [31-OFFSET_W:0] pfn_t;
    typedef logic [1:0]           reg_idx_t;
    typedef logic [15:0]          count_t;
    typedef logic [3:0]           ie_type_t;

    typedef struct packed {
        vpn_t vpn;
        pfn_t pfn;
        logic valid;
        logic present;
        logic writable;
    } tlb_entry_t;

    typedef tlb_entry_t [TLB_ENTRIES-1:0] tlb_table_t;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_rw_e;

    // the register sources come first so the low two bits index regs
    typedef enum logic [2:0] {
        SRC_REG0 = 3'd0,
        SRC_REG1 = 3'd1,
        SRC_REG2 = 3'd2,
        SRC_REG3 = 3'd3,
        SRC_MEM1 = 3'd4,
        SRC_MEM2 = 3'd5,
        SRC_IMM  = 3'd6,
        SRC_EIP  = 3'd7
    } op_src_e;

    typedef enum logic [1:0] {
        DEST_NONE = 2'd0,
        DEST_REG  = 2'd1,
        DEST_MEM  = 2'd2
    } dest_kind_e;

    typedef struct packed {
        logic                                  valid;
        word_t                                 eip;
        addr_t                                 mem_addr1;
        addr_t                                 mem_addr2;
        mem_rw_e                               mem1_rw;
        mem_rw_e                               mem2_rw;
        word_t      [NUM_OPS-1:0]              regs;
        word_t                                 imm;
        op_src_e    [NUM_OPS-1:0]              op_sel;
        dest_kind_e [NUM_DESTS-1:0]            dest_kind;
        reg_idx_t   [NUM_DESTS-1:0]            dest_reg;
        logic                                  is_rep;
        count_t                                rep_count;
        logic                                  dir_down;   // string ops walk downwards
        logic                                  ie;
        ie_type_t                              ie_type;
    } uop_t;

    typedef struct packed {
        addr_t paddr;
        logic  miss;
        logic  prot;
    } xlat_t;

    typedef struct packed {
        logic                   valid;
        word_t                  eip;
        word_t [NUM_OPS-1:0]    ops;
        addr_t [NUM_DESTS-1:0]  dest_addr;
        logic  [NUM_DESTS-1:0]  dest_is_mem;
        logic                   ie;
        ie_type_t               ie_type;
    } result_t;

    typedef enum logic {
        REP_IDLE = 1'b0,
        REP_RUN  = 1'b1
    } rep_state_e;

endpackage
